// File: source/idct_macros.svh
// block geometry, pass shifts and accumulator width for the 8x8 IDCT
`ifndef IDCT_MACROS_SVH
`define IDCT_MACROS_SVH

// side length of one block
`define DCT_N 8

// table is scaled by 4096, split as 2^8 after rows
`define DCT_PASS1_SHIFT 8

// and 2^16 after columns, undoing both table scales
`define DCT_PASS2_SHIFT 16

// wide enough for 8 products of 32-bit T by 13-bit coef
`define DCT_ACC_WIDTH 48

`endif

// File: source/dct_coef_pkg.sv
// cosine table and arithmetic types
`default_nettype none

`include "idct_macros.svh"

package dct_coef_pkg;

	// frequency or position select into the table
	typedef logic [2:0] cos_sel_t;

	// scaled basis value, +/-2008 at most
	typedef logic signed [12:0] coef_t;

	// running sum of one 8-term dot product
	typedef logic signed [`DCT_ACC_WIDTH-1:0] acc_t;

	// which half of the 2-D transform is running
	typedef enum logic {
		PASS_ROW = 1'b0,
		PASS_COL = 1'b1
	} pass_t;

endpackage

`default_nettype wire

// File: source/block_pkg.sv
// block data types and the 6-bit block index union
`default_nettype none

package block_pkg;

	// signed input coefficient from the host
	typedef logic signed [15:0] freq_coef_t;

	// intermediate T value after the row pass
	typedef logic signed [31:0] inter_t;

	// output pixel
	typedef logic [7:0] sample_t;

	// row in the upper bits so linear order is raster order
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} blk_rc_t;

	// counters step linear, table and buffers see row/col
	typedef union packed {
		logic [5:0] linear;
		blk_rc_t    rc;
	} blk_index_u;

endpackage

`default_nettype wire

// File: source/mac_ctl_if.sv
// sequencer to MAC operand, control and result bundle
`timescale 1ns/1ps
`default_nettype none

interface mac_ctl_if;
	import dct_coef_pkg::*;
	import block_pkg::*;

	// one term per cycle while acc_valid
	logic   acc_valid;
	// first term loads, last term closes the sum
	logic   acc_first;
	logic   acc_last;
	pass_t  pass;
	coef_t  coef;
	inter_t operand;
	// shifted and, in the column pass, clipped sum
	logic   res_valid;
	inter_t res;

	modport seq (
		output acc_valid, acc_first, acc_last, pass, coef, operand,
		input  res_valid, res
	);

	modport mac (
		input  acc_valid, acc_first, acc_last, pass, coef, operand,
		output res_valid, res
	);

endinterface

`default_nettype wire

// File: source/dct_coef_rom.sv
// 8x8 DCT-II basis table scaled by 4096
`timescale 1ns/1ps
`default_nettype none

module dct_coef_rom (
	input  dct_coef_pkg::cos_sel_t freq,
	input  dct_coef_pkg::cos_sel_t pos,
	output dct_coef_pkg::coef_t    value
);
	always_comb begin
		value = '0;
		case ({freq, pos})
			// dc row, flat 1448 = 4096/(2*sqrt 2)
			6'd0:  value = 13'sd1448;
			6'd1:  value = 13'sd1448;
			6'd2:  value = 13'sd1448;
			6'd3:  value = 13'sd1448;
			6'd4:  value = 13'sd1448;
			6'd5:  value = 13'sd1448;
			6'd6:  value = 13'sd1448;
			6'd7:  value = 13'sd1448;
			// freq 1
			6'd8:  value = 13'sd2008;
			6'd9:  value = 13'sd1702;
			6'd10: value = 13'sd1137;
			6'd11: value = 13'sd399;
			6'd12: value = -13'sd399;
			6'd13: value = -13'sd1137;
			6'd14: value = -13'sd1702;
			6'd15: value = -13'sd2008;
			// freq 2
			6'd16: value = 13'sd1892;
			6'd17: value = 13'sd783;
			6'd18: value = -13'sd783;
			6'd19: value = -13'sd1892;
			6'd20: value = -13'sd1892;
			6'd21: value = -13'sd783;
			6'd22: value = 13'sd783;
			6'd23: value = 13'sd1892;
			// freq 3
			6'd24: value = 13'sd1702;
			6'd25: value = -13'sd399;
			6'd26: value = -13'sd2008;
			6'd27: value = -13'sd1137;
			6'd28: value = 13'sd1137;
			6'd29: value = 13'sd2008;
			6'd30: value = 13'sd399;
			6'd31: value = -13'sd1702;
			// freq 4
			6'd32: value = 13'sd1448;
			6'd33: value = -13'sd1448;
			6'd34: value = -13'sd1448;
			6'd35: value = 13'sd1448;
			6'd36: value = 13'sd1448;
			6'd37: value = -13'sd1448;
			6'd38: value = -13'sd1448;
			6'd39: value = 13'sd1448;
			// freq 5
			6'd40: value = 13'sd1137;
			6'd41: value = -13'sd2008;
			6'd42: value = 13'sd399;
			6'd43: value = 13'sd1702;
			6'd44: value = -13'sd1702;
			6'd45: value = -13'sd399;
			6'd46: value = 13'sd2008;
			6'd47: value = -13'sd1137;
			// freq 6
			6'd48: value = 13'sd783;
			6'd49: value = -13'sd1892;
			6'd50: value = 13'sd1892;
			6'd51: value = -13'sd783;
			6'd52: value = -13'sd783;
			6'd53: value = 13'sd1892;
			6'd54: value = -13'sd1892;
			6'd55: value = 13'sd783;
			// freq 7
			6'd56: value = 13'sd399;
			6'd57: value = -13'sd1137;
			6'd58: value = 13'sd1702;
			6'd59: value = -13'sd2008;
			6'd60: value = 13'sd2008;
			6'd61: value = -13'sd1702;
			6'd62: value = 13'sd1137;
			6'd63: value = -13'sd399;
			default: value = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/block_buffer.sv
// 64-word block store, one write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "idct_macros.svh"

module block_buffer #(
	parameter int WIDTH = 16
) (
	input  logic                   clk,
	input  logic                   wr_en,
	input  block_pkg::blk_index_u  wr_index,
	input  logic [WIDTH-1:0]       wr_data,
	input  block_pkg::blk_index_u  rd_index,
	output logic [WIDTH-1:0]       rd_data
);
	// one word per block element, contents kept across blocks
	logic [WIDTH-1:0] mem [`DCT_N*`DCT_N];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index.linear] <= wr_data;
		end
		// read of an address written this cycle returns the old word
		rd_data <= mem[rd_index.linear];
	end

endmodule

`default_nettype wire

// File: source/idct_mac.sv
// multiply-accumulate with per-pass shift and pixel clipping
`timescale 1ns/1ps
`default_nettype none

`include "idct_macros.svh"

module idct_mac (
	input logic     clk,
	input logic     rst_n,
	mac_ctl_if.mac  ctl
);
	import dct_coef_pkg::*;
	import block_pkg::*;

	acc_t acc;
	acc_t product;
	acc_t sum;
	acc_t shifted;
	acc_t clipped;

	// both operands widened before the multiply
	assign product = acc_t'(ctl.operand) * acc_t'(ctl.coef);
	// first term starts a fresh sum
	assign sum = ctl.acc_first ? product : acc + product;

	// arithmetic shifts, so rounding goes toward minus infinity
	always_comb begin
		if (ctl.pass == PASS_COL) begin
			shifted = sum >>> `DCT_PASS2_SHIFT;
		end else begin
			shifted = sum >>> `DCT_PASS1_SHIFT;
		end
		clipped = shifted;
		// pixels only in the column pass
		if (ctl.pass == PASS_COL) begin
			if (shifted < 0) begin
				clipped = '0;
			end else if (shifted > 255) begin
				clipped = acc_t'(255);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctl.acc_valid) begin
			acc <= sum;
		end
		if (ctl.acc_valid && ctl.acc_last) begin
			ctl.res <= inter_t'(clipped);
		end
	end

	// result strobe one cycle after the closing term
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctl.res_valid <= 1'b0;
		end else begin
			ctl.res_valid <= ctl.acc_valid && ctl.acc_last;
		end
	end

endmodule

`default_nettype wire

// File: source/idct_sequencer.sv
// block FSM, index counters and result routing for the two IDCT passes
`timescale 1ns/1ps
`default_nettype none

module idct_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	output logic                   busy,
	output block_pkg::blk_index_u  in_rd_index,
	input  block_pkg::freq_coef_t  in_rd_data,
	output block_pkg::blk_index_u  t_rd_index,
	input  block_pkg::inter_t      t_rd_data,
	output logic                   t_wr_en,
	output block_pkg::blk_index_u  t_wr_index,
	output dct_coef_pkg::cos_sel_t rom_freq,
	output dct_coef_pkg::cos_sel_t rom_pos,
	input  dct_coef_pkg::coef_t    rom_value,
	mac_ctl_if.seq                 ctl,
	output logic                   sample_valid,
	output block_pkg::blk_index_u  sample_index,
	output logic                   done
);
	import dct_coef_pkg::*;
	import block_pkg::*;

	typedef enum logic [2:0] {IDLE, ROW, DRAIN, COL, FINISH} state_t;

	state_t     state;
	// element being issued and its term
	blk_index_u out_idx;
	cos_sel_t   k_cnt;
	logic       issue;
	logic       last_term;
	pass_t      issue_pass;

	// stage 1, lines up with the registered buffer read
	logic       valid_d1;
	logic       first_d1;
	logic       last_d1;
	pass_t      pass_d1;
	coef_t      coef_d1;
	blk_index_u idx_d1;
	// stage 2, lines up with res_valid
	pass_t      pass_d2;
	blk_index_u idx_d2;

	assign issue = (state == ROW) || (state == COL);
	assign last_term = (k_cnt == 3'd7);
	assign issue_pass = (state == COL) ? PASS_COL : PASS_ROW;
	assign busy = (state != IDLE);

	// rows read X[r][k] and C[k][c], columns read T[k][c] and C[k][r]
	always_comb begin
		in_rd_index.rc.row = out_idx.rc.row;
		in_rd_index.rc.col = k_cnt;
		t_rd_index.rc.row = k_cnt;
		t_rd_index.rc.col = out_idx.rc.col;
		rom_freq = k_cnt;
		rom_pos = (state == COL) ? out_idx.rc.row : out_idx.rc.col;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			out_idx <= '0;
			k_cnt <= '0;
		end else begin
			case (state)
				IDLE: if (start) state <= ROW;
				ROW: if (last_term && out_idx.linear == 6'd63) state <= DRAIN;
				// columns wait for the last T word to land
				DRAIN: if (t_wr_en && t_wr_index.linear == 6'd63) state <= COL;
				COL: if (last_term && out_idx.linear == 6'd63) state <= FINISH;
				FINISH: if (done) state <= IDLE;
				default: state <= IDLE;
			endcase
			// both counters wrap back to zero at pass end
			if (issue) begin
				k_cnt <= k_cnt + 3'd1;
				if (last_term) begin
					out_idx.linear <= out_idx.linear + 6'd1;
				end
			end
		end
	end

	// control pipeline
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_d1 <= 1'b0;
			first_d1 <= 1'b0;
			last_d1 <= 1'b0;
			pass_d1 <= PASS_ROW;
			pass_d2 <= PASS_ROW;
		end else begin
			valid_d1 <= issue;
			first_d1 <= issue && (k_cnt == 3'd0);
			last_d1 <= issue && last_term;
			pass_d1 <= issue_pass;
			pass_d2 <= pass_d1;
		end
	end

	// table value registered beside the buffer read
	always_ff @(posedge clk) begin
		coef_d1 <= rom_value;
		idx_d1 <= out_idx;
		idx_d2 <= idx_d1;
	end

	assign ctl.acc_valid = valid_d1;
	assign ctl.acc_first = first_d1;
	assign ctl.acc_last = last_d1;
	assign ctl.pass = pass_d1;
	assign ctl.coef = coef_d1;
	// row pass operands are sign-extended input coefficients
	assign ctl.operand = (pass_d1 == PASS_COL) ? t_rd_data : inter_t'(in_rd_data);

	// row results go to the T buffer, column results out
	assign t_wr_en = ctl.res_valid && (pass_d2 == PASS_ROW);
	assign t_wr_index = idx_d2;
	assign sample_valid = ctl.res_valid && (pass_d2 == PASS_COL);
	assign sample_index = idx_d2;
	assign done = sample_valid && (idx_d2.linear == 6'd63);

endmodule

`default_nettype wire

// File: source/idct_top.sv
// 8x8 IDCT engine top, buffers, table, sequencer and MAC
`timescale 1ns/1ps
`default_nettype none

module idct_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   coef_wr,
	input  logic [5:0]             coef_index,
	input  block_pkg::freq_coef_t  coef_data,
	input  logic                   start,
	output logic                   busy,
	output logic                   sample_valid,
	output logic [5:0]             sample_index,
	output block_pkg::sample_t     sample,
	output logic                   done
);
	import dct_coef_pkg::*;
	import block_pkg::*;

	logic       in_wr_en;
	blk_index_u wr_idx;
	blk_index_u in_rd_index;
	freq_coef_t in_rd_data;
	blk_index_u t_rd_index;
	inter_t     t_rd_data;
	logic       t_wr_en;
	blk_index_u t_wr_index;
	cos_sel_t   rom_freq;
	cos_sel_t   rom_pos;
	coef_t      rom_value;
	blk_index_u out_index;

	mac_ctl_if mac_bus ();

	// host writes only land while idle
	assign in_wr_en = coef_wr && !busy;
	assign wr_idx.linear = coef_index;

	block_buffer #(.WIDTH(16)) u_in_buf (
		.clk(clk), .wr_en(in_wr_en), .wr_index(wr_idx), .wr_data(coef_data),
		.rd_index(in_rd_index), .rd_data(in_rd_data)
	);

	// T buffer takes row-pass results straight from the MAC
	block_buffer #(.WIDTH(32)) u_t_buf (
		.clk(clk), .wr_en(t_wr_en), .wr_index(t_wr_index), .wr_data(mac_bus.res),
		.rd_index(t_rd_index), .rd_data(t_rd_data)
	);

	dct_coef_rom u_rom (.freq(rom_freq), .pos(rom_pos), .value(rom_value));

	idct_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .start(start), .busy(busy),
		.in_rd_index(in_rd_index), .in_rd_data(in_rd_data),
		.t_rd_index(t_rd_index), .t_rd_data(t_rd_data),
		.t_wr_en(t_wr_en), .t_wr_index(t_wr_index),
		.rom_freq(rom_freq), .rom_pos(rom_pos), .rom_value(rom_value),
		.ctl(mac_bus.seq), .sample_valid(sample_valid),
		.sample_index(out_index), .done(done)
	);

	idct_mac u_mac (.clk(clk), .rst_n(rst_n), .ctl(mac_bus.mac));

	// column results are already clipped to 0..255
	assign sample = mac_bus.res[7:0];
	assign sample_index = out_index.linear;

endmodule

`default_nettype wire

// File: tb/idct_tb.sv
// testbench for the 8x8 IDCT engine with reference model, LCG stimulus and watchdog
`timescale 1ns/1ps
`default_nettype none

module idct_tb;
	import block_pkg::*;

	localparam int NUM_BLOCKS = 13;
	localparam int DONE_LIMIT = 2000;
	localparam real WATCHDOG_NS = NUM_BLOCKS * 1500 * 10.0 + 2000.0;
	localparam real PI = 3.14159265358979;

	logic       clk;
	logic       rst_n;
	logic       coef_wr;
	logic [5:0] coef_index;
	freq_coef_t coef_data;
	logic       start;
	logic       busy;
	logic       sample_valid;
	logic [5:0] sample_index;
	sample_t    sample;
	logic       done;

	// model state with the host copy of the block and expected pixels
	int          x_ref [64];
	int          cos_tab [64];
	int          exp_s [64];
	logic [31:0] lcg_state;
	// monitor results
	logic [7:0]  got_val [$];
	logic [5:0]  got_idx [$];
	int          done_cnt;
	logic        after_done;
	int          errors;
	int          err_mark;
	int          n_tests;
	int          n_failed;

	idct_top u_idct_top (
		.clk(clk), .rst_n(rst_n), .coef_wr(coef_wr), .coef_index(coef_index),
		.coef_data(coef_data), .start(start), .busy(busy),
		.sample_valid(sample_valid), .sample_index(sample_index),
		.sample(sample), .done(done)
	);

	always #5 clk = ~clk;

	// hard stop sized from the block count
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	// 32-bit LCG with numerical recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits give -2048..2047
	function automatic int rand_coef();
		logic [31:0] r;
		r = lcg_next();
		return int'({20'd0, r[27:16]}) - 2048;
	endfunction

	// orthonormal DCT-II basis times 4096 truncated toward zero
	function automatic void build_cos_table();
		real a;
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8; j++) begin
				a = 2048.0 * $cos(real'((2 * j + 1) * i) * PI / 16.0);
				if (i == 0) begin
					a = a / $sqrt(2.0);
				end
				cos_tab[i * 8 + j] = $rtoi(a);
			end
		end
	endfunction

	// T = X*C >>> 8 and then S = clip(C'*T >>> 16)
	function automatic void compute_expected();
		longint acc;
		longint t_val [64];
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				acc = 0;
				for (int k = 0; k < 8; k++) begin
					acc += longint'(x_ref[r * 8 + k]) * longint'(cos_tab[k * 8 + c]);
				end
				t_val[r * 8 + c] = acc >>> 8;
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				acc = 0;
				for (int k = 0; k < 8; k++) begin
					acc += longint'(cos_tab[k * 8 + r]) * t_val[k * 8 + c];
				end
				acc = acc >>> 16;
				if (acc < 0) acc = 0;
				if (acc > 255) acc = 255;
				exp_s[r * 8 + c] = int'(acc);
			end
		end
	endfunction

	// inputs change 1 ns after the edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_block();
		for (int i = 0; i < 64; i++) begin
			step_cycle();
			coef_wr = 1'b1;
			coef_index = 6'(i);
			coef_data = 16'(x_ref[i]);
		end
		step_cycle();
		coef_wr = 1'b0;
	endtask

	function automatic void clear_block();
		for (int i = 0; i < 64; i++) begin
			x_ref[i] = 0;
		end
	endfunction

	// one start with optional traffic while busy and a compare of 64 samples
	task automatic run_block(input string name, input bit disturb, input int fixed);
		int start_done;
		int waited;
		compute_expected();
		if (fixed >= 0) begin
			for (int i = 0; i < 64; i++) begin
				exp_s[i] = fixed;
			end
		end
		got_val.delete();
		got_idx.delete();
		start_done = done_cnt;
		step_cycle();
		start = 1'b1;
		step_cycle();
		start = 1'b0;
		if (disturb) begin
			// writes that must be dropped so x_ref keeps the old block
			for (int i = 0; i < 8; i++) begin
				step_cycle();
				coef_wr = 1'b1;
				coef_index = 6'(i * 9);
				coef_data = 16'(x_ref[i * 9] + 100);
			end
			step_cycle();
			coef_wr = 1'b0;
			start = 1'b1;
			step_cycle();
			start = 1'b0;
		end
		waited = 0;
		while (done_cnt == start_done && waited < DONE_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (done_cnt == start_done) begin
			$display("%s: done did not arrive within %0d cycles", name, DONE_LIMIT);
			errors++;
		end
		// a latched second start would bring busy back here
		repeat (20) begin
			@(negedge clk);
			assert (!busy) else begin
				$display("%s: busy rose again after done", name);
				errors++;
			end
		end
		assert (got_val.size() == 64) else begin
			$display("Error %s expected %0d actual %0d (sample count)", name, 64, got_val.size());
			errors++;
		end
		for (int i = 0; i < got_val.size() && i < 64; i++) begin
			assert (int'(got_idx[i]) == i) else begin
				$display("Error %s expected %0d actual %0d (index)", name, i, got_idx[i]);
				errors++;
			end
			assert (int'(got_val[i]) == exp_s[i]) else begin
				$display("Error %s expected %0d actual %0d (sample %0d)",
					name, exp_s[i], got_val[i], i);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		if (errors == err_mark) begin
			$display("%-12s ok", name);
		end else begin
			n_failed++;
			$display("%-12s FAILED with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// sample collection, done alignment and busy after done
	always @(negedge clk) begin
		if (rst_n) begin
			if (after_done) begin
				assert (!busy) else begin
					$display("busy still high on the cycle after done");
					errors++;
				end
			end
			after_done = done;
			if (sample_valid) begin
				got_val.push_back(sample);
				got_idx.push_back(sample_index);
			end
			if (done) begin
				assert (sample_valid && got_val.size() == 64) else begin
					$display("done did not line up with the 64th sample");
					errors++;
				end
				done_cnt++;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		coef_wr = 1'b0;
		coef_index = '0;
		coef_data = '0;
		start = 1'b0;
		lcg_state = 32'hc702_292c;
		done_cnt = 0;
		after_done = 1'b0;
		errors = 0;
		err_mark = 0;
		n_tests = 0;
		n_failed = 0;
		build_cos_table();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// idle outputs with no start
		repeat (20) begin
			@(negedge clk);
			assert (!busy && !sample_valid && !done) else begin
				$display("reset: an output went high without a start");
				errors++;
			end
		end
		finish_test("reset");

		// flat block gives 127 everywhere
		clear_block();
		x_ref[0] = 1024;
		load_block();
		run_block("dc", 1'b0, 127);
		finish_test("dc");

		for (int b = 0; b < 8; b++) begin
			for (int i = 0; i < 64; i++) begin
				x_ref[i] = rand_coef();
			end
			load_block();
			run_block($sformatf("random%0d", b), 1'b0, -1);
		end
		finish_test("random");

		clear_block();
		x_ref[0] = -2048;
		load_block();
		run_block("clip_low", 1'b0, 0);
		finish_test("clip_low");

		// strong dc plus one ac term reaching both clip limits
		clear_block();
		x_ref[0] = 2047;
		x_ref[1] = 1500;
		load_block();
		run_block("clip_high", 1'b0, -1);
		finish_test("clip_high");

		// writes and start while busy and a rerun of the same buffer
		for (int i = 0; i < 64; i++) begin
			x_ref[i] = rand_coef();
		end
		load_block();
		run_block("busy_writes", 1'b1, -1);
		run_block("busy_rerun", 1'b0, -1);
		finish_test("busy");

		$display("tests %0d, failing tests %0d, errors %0d", n_tests, n_failed, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/dct_coef_pkg.sv
source/block_pkg.sv
source/mac_ctl_if.sv
source/dct_coef_rom.sv
source/block_buffer.sv
source/idct_mac.sv
source/idct_sequencer.sv
source/idct_top.sv
tb/idct_tb.sv

// File: Makefile
# Verilator build and run for the 8x8 IDCT engine

VERILATOR ?= verilator
TOP       ?= idct_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
